//--- Makefile
SIM  := obj_dir/Vgame_top_tb
SRCS := $(shell cat all.f)

.PHONY: all run clean

all: run

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module game_top_tb

run: $(SIM) source/start_button.mem source/again_button.mem
	./$(SIM) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
source/vga_pkg.sv
source/vga_timing.sv
source/bg_draw.sv
source/game_screen.sv
source/game_fsm.sv
source/game_top.sv
tests/game_top_tb.sv

//--- source/again_button.mem
// again button, 8 pixels per row, 4 rows, row-major, 00F is transparent
00F
C62
C62
C62
C62
C62
C62
00F
C62
C62
FFF
FFF
FFF
FFF
C62
C62
C62
C62
FFF
C62
C62
FFF
C62
C62
00F
C62
FFF
FFF
FFF
C62
C62
00F

//--- source/bg_draw.sv
`timescale 1ns/1ps
`default_nettype none

module bg_draw (
    input  logic                clk,
    input  logic                rst,
    input  vga_pkg::game_state_e state,
    input  logic [10:0]         hcount_in,
    input  logic [10:0]         vcount_in,
    input  logic                hsync_in,
    input  logic                vsync_in,
    input  logic                hblnk_in,
    input  logic                vblnk_in,
    output logic [10:0]         hcount_out,
    output logic [10:0]         vcount_out,
    output logic                hsync_out,
    output logic                vsync_out,
    output logic                hblnk_out,
    output logic                vblnk_out,
    output logic [11:0]         rgb_out
);
    import vga_pkg::*;

    logic [11:0] rgb_nxt;

    always_comb begin
        if (hblnk_in || vblnk_in) begin
            rgb_nxt = 12'h000;   // nothing may be driven in blanking
        end else begin
            case (state)
                STATE_MENU: rgb_nxt = COLOR_MENU;
                STATE_PLAY: rgb_nxt = COLOR_PLAY;
                STATE_OVER: rgb_nxt = COLOR_OVER;
                default:    rgb_nxt = 12'h000;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= hcount_in;
            vcount_out <= vcount_in;
            hsync_out  <= hsync_in;
            vsync_out  <= vsync_in;
            hblnk_out  <= hblnk_in;
            vblnk_out  <= vblnk_in;
            rgb_out    <= rgb_nxt;
        end
    end

    a_black_in_hblank: assert property (
        @(posedge clk) disable iff (rst) hblnk_out |-> (rgb_out == 12'h000)
    );

endmodule

`default_nettype wire

//--- source/game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_fsm #(
    parameter int ROUND_FRAMES = 300
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 vsync,
    input  logic                 game_start,
    input  logic                 back_to_menu,
    output vga_pkg::game_state_e state
);
    import vga_pkg::*;

    localparam int FC_W = $clog2(ROUND_FRAMES + 1);

    logic            vsync_d;
    logic            vsync_rise;
    logic [FC_W-1:0] frame_cnt;

    assign vsync_rise = vsync && !vsync_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= STATE_MENU;
            vsync_d   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            vsync_d <= vsync;
            case (state)
                STATE_MENU: begin
                    if (game_start) begin
                        state     <= STATE_PLAY;
                        frame_cnt <= '0;
                    end
                end
                STATE_PLAY: begin
                    if (vsync_rise) begin
                        if (frame_cnt == FC_W'(ROUND_FRAMES - 1))
                            state <= STATE_OVER;   // round over
                        else
                            frame_cnt <= frame_cnt + 1'b1;
                    end
                end
                STATE_OVER: begin
                    if (back_to_menu)
                        state <= STATE_MENU;
                end
                default: state <= STATE_MENU;
            endcase
        end
    end

    a_legal_state: assert property (
        @(posedge clk) disable iff (rst)
        state inside {STATE_MENU, STATE_PLAY, STATE_OVER}
    );

endmodule

`default_nettype wire

//--- source/game_screen.sv
`timescale 1ns/1ps
`default_nettype none

module game_screen #(
    parameter int CLICK_COOLDOWN = 20
) (
    input  logic                clk,
    input  logic                rst,
    input  vga_pkg::game_state_e state,
    input  logic [11:0]         mouse_x,
    input  logic [11:0]         mouse_y,
    input  logic                mouse_clicked,
    input  logic [10:0]         hcount_in,
    input  logic [10:0]         vcount_in,
    input  logic                hsync_in,
    input  logic                vsync_in,
    input  logic                hblnk_in,
    input  logic                vblnk_in,
    input  logic [11:0]         rgb_in,
    output logic                hsync_out,
    output logic                vsync_out,
    output logic [11:0]         rgb_out,
    output logic                game_start,
    output logic                back_to_menu
);
    import vga_pkg::*;

    localparam int ROM_DEPTH = SPRITE_W * SPRITE_H;
    localparam int ADDR_W    = $clog2(ROM_DEPTH);
    localparam int CD_W      = $clog2(CLICK_COOLDOWN + 2);
    localparam logic [CD_W-1:0] COOLDOWN_LOAD = CD_W'(CLICK_COOLDOWN);

    logic [11:0] start_rom [0:ROM_DEPTH-1];
    logic [11:0] again_rom [0:ROM_DEPTH-1];

    logic [10:0]       rel_x;
    logic [10:0]       rel_y;
    logic [ADDR_W-1:0] rom_addr;
    logic [11:0]       sprite_px;
    logic              in_btn;
    logic              mouse_in_btn;
    logic [11:0]       rgb_nxt;
    logic [CD_W-1:0]   start_cd;
    logic [CD_W-1:0]   back_cd;

    initial begin
        $readmemh("source/start_button.mem", start_rom);
        $readmemh("source/again_button.mem", again_rom);
    end

    always_comb begin
        rel_x    = hcount_in - 11'(BTN_X);
        rel_y    = vcount_in - 11'(BTN_Y);
        // one sprite pixel per 16x16 block
        rom_addr = ADDR_W'((rel_y >> SPRITE_SCALE_LOG2) * SPRITE_W
                           + (rel_x >> SPRITE_SCALE_LOG2));
        in_btn   = !hblnk_in && !vblnk_in
                   && (hcount_in >= BTN_X) && (hcount_in < BTN_X + BTN_W)
                   && (vcount_in >= BTN_Y) && (vcount_in < BTN_Y + BTN_H);
        sprite_px = (state == STATE_OVER) ? again_rom[rom_addr] : start_rom[rom_addr];

        rgb_nxt = rgb_in;
        if (in_btn && (state != STATE_PLAY) && (sprite_px != TRANSPARENT))
            rgb_nxt = sprite_px;
    end

    assign mouse_in_btn = (mouse_x >= BTN_X) && (mouse_x < BTN_X + BTN_W)
                          && (mouse_y >= BTN_Y) && (mouse_y < BTN_Y + BTN_H);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_start   <= 1'b0;
            back_to_menu <= 1'b0;
            start_cd     <= '0;
            back_cd      <= '0;
        end else begin
            game_start   <= 1'b0;   // strobes last one cycle
            back_to_menu <= 1'b0;
            if (start_cd != '0)
                start_cd <= start_cd - 1'b1;
            if (back_cd != '0)
                back_cd <= back_cd - 1'b1;

            // reload both so one press cannot carry into the next screen
            if (mouse_clicked && mouse_in_btn) begin
                if (state == STATE_MENU && start_cd == '0) begin
                    game_start <= 1'b1;
                    start_cd   <= COOLDOWN_LOAD;
                    back_cd    <= COOLDOWN_LOAD;
                end else if (state == STATE_OVER && back_cd == '0) begin
                    back_to_menu <= 1'b1;
                    start_cd     <= COOLDOWN_LOAD;
                    back_cd      <= COOLDOWN_LOAD;
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
            rgb_out   <= '0;
        end else begin
            hsync_out <= hsync_in;
            vsync_out <= vsync_in;
            rgb_out   <= rgb_nxt;
        end
    end

    a_one_strobe: assert property (
        @(posedge clk) disable iff (rst) !(game_start && back_to_menu)
    );

endmodule

`default_nettype wire

//--- source/game_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_top #(
    parameter int CLICK_COOLDOWN = 20,
    parameter int ROUND_FRAMES   = 300
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [11:0]          mouse_x,
    input  logic [11:0]          mouse_y,
    input  logic                 mouse_clicked,
    output logic                 hsync,
    output logic                 vsync,
    output logic [11:0]          rgb,
    output vga_pkg::game_state_e state
);

    // raster straight from the counters
    logic [10:0] tim_hcount;
    logic [10:0] tim_vcount;
    logic        tim_hsync;
    logic        tim_vsync;
    logic        tim_hblnk;
    logic        tim_vblnk;

    // one cycle later with background
    logic [10:0] bg_hcount;
    logic [10:0] bg_vcount;
    logic        bg_hsync;
    logic        bg_vsync;
    logic        bg_hblnk;
    logic        bg_vblnk;
    logic [11:0] bg_rgb;

    logic        game_start;
    logic        back_to_menu;

    vga_timing u_vga_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .hblnk  (tim_hblnk),
        .vblnk  (tim_vblnk)
    );

    bg_draw u_bg_draw (
        .clk        (clk),
        .rst        (rst),
        .state      (state),
        .hcount_in  (tim_hcount),
        .vcount_in  (tim_vcount),
        .hsync_in   (tim_hsync),
        .vsync_in   (tim_vsync),
        .hblnk_in   (tim_hblnk),
        .vblnk_in   (tim_vblnk),
        .hcount_out (bg_hcount),
        .vcount_out (bg_vcount),
        .hsync_out  (bg_hsync),
        .vsync_out  (bg_vsync),
        .hblnk_out  (bg_hblnk),
        .vblnk_out  (bg_vblnk),
        .rgb_out    (bg_rgb)
    );

    game_screen #(
        .CLICK_COOLDOWN (CLICK_COOLDOWN)
    ) u_game_screen (
        .clk           (clk),
        .rst           (rst),
        .state         (state),
        .mouse_x       (mouse_x),
        .mouse_y       (mouse_y),
        .mouse_clicked (mouse_clicked),
        .hcount_in     (bg_hcount),
        .vcount_in     (bg_vcount),
        .hsync_in      (bg_hsync),
        .vsync_in      (bg_vsync),
        .hblnk_in      (bg_hblnk),
        .vblnk_in      (bg_vblnk),
        .rgb_in        (bg_rgb),
        .hsync_out     (hsync),
        .vsync_out     (vsync),
        .rgb_out       (rgb),
        .game_start    (game_start),
        .back_to_menu  (back_to_menu)
    );

    game_fsm #(
        .ROUND_FRAMES (ROUND_FRAMES)
    ) u_game_fsm (
        .clk          (clk),
        .rst          (rst),
        .vsync        (tim_vsync),   // frame edges taken at the source
        .game_start   (game_start),
        .back_to_menu (back_to_menu),
        .state        (state)
    );

endmodule

`default_nettype wire

//--- source/start_button.mem
// start button, 8 pixels per row, 4 rows, row-major, 00F is transparent
00F
3B3
3B3
3B3
3B3
3B3
3B3
00F
3B3
3B3
3B3
FFF
3B3
3B3
3B3
3B3
3B3
3B3
3B3
FFF
FFF
3B3
3B3
3B3
00F
3B3
3B3
FFF
3B3
3B3
3B3
00F

//--- source/vga_pkg.sv
`default_nettype none

package vga_pkg;

    // 800x600 @ 60 Hz with a 40 MHz pixel clock
    localparam int HOR_PIXELS     = 800;
    localparam int VER_PIXELS     = 600;
    localparam int HOR_TOTAL      = 1056;
    localparam int VER_TOTAL      = 628;
    localparam int HOR_SYNC_START = 840;
    localparam int HOR_SYNC_END   = 968;   // exclusive
    localparam int VER_SYNC_START = 601;
    localparam int VER_SYNC_END   = 605;   // exclusive

    localparam int SPRITE_W          = 8;
    localparam int SPRITE_H          = 4;
    localparam int SPRITE_SCALE_LOG2 = 4;   // 16x16 screen pixels per sprite pixel
    localparam int BTN_W             = 128;
    localparam int BTN_H             = 64;
    localparam int BTN_X             = (HOR_PIXELS - BTN_W) / 2;
    localparam int BTN_Y             = (VER_PIXELS - BTN_H) / 3;

    localparam logic [11:0] TRANSPARENT = 12'h00F;
    localparam logic [11:0] COLOR_MENU  = 12'h235;
    localparam logic [11:0] COLOR_PLAY  = 12'h2A2;
    localparam logic [11:0] COLOR_OVER  = 12'hA22;

    typedef enum logic [1:0] {
        STATE_MENU = 2'd0,
        STATE_PLAY = 2'd1,
        STATE_OVER = 2'd2
    } game_state_e;

endpackage

`default_nettype wire

//--- source/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  logic        clk,
    input  logic        rst,
    output logic [10:0] hcount,
    output logic [10:0] vcount,
    output logic        hsync,
    output logic        vsync,
    output logic        hblnk,
    output logic        vblnk
);
    import vga_pkg::*;

    logic [10:0] hcount_nxt;
    logic [10:0] vcount_nxt;

    always_comb begin
        hcount_nxt = hcount + 11'd1;
        vcount_nxt = vcount;
        if (hcount == 11'(HOR_TOTAL - 1)) begin
            hcount_nxt = '0;
            if (vcount == 11'(VER_TOTAL - 1))
                vcount_nxt = '0;
            else
                vcount_nxt = vcount + 11'd1;
        end
    end

    // decode from the next count so sync and blanking line up with the counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= (hcount_nxt >= HOR_SYNC_START) && (hcount_nxt < HOR_SYNC_END);
            vsync  <= (vcount_nxt >= VER_SYNC_START) && (vcount_nxt < VER_SYNC_END);
            hblnk  <= (hcount_nxt >= HOR_PIXELS);
            vblnk  <= (vcount_nxt >= VER_PIXELS);
        end
    end

endmodule

`default_nettype wire

//--- tests/game_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module game_top_tb;
    import vga_pkg::*;

    localparam int ROUND_FRAMES   = 2;
    localparam int CLICK_COOLDOWN = 20;
    localparam int CLK_PERIOD     = 8;
    localparam int FRAME_CYCLES   = HOR_TOTAL * VER_TOTAL;
    localparam int WATCHDOG_NS    = 4 * FRAME_CYCLES * CLK_PERIOD + 100000;

    logic        clk;
    logic        rst;
    logic [11:0] mouse_x;
    logic [11:0] mouse_y;
    logic        mouse_clicked;
    logic        hsync;
    logic        vsync;
    logic [11:0] rgb;
    game_state_e state;

    logic [11:0] start_px [0:SPRITE_W*SPRITE_H-1];
    logic [11:0] again_px [0:SPRITE_W*SPRITE_H-1];
    logic [31:0] lfsr;

    // reference model of raster, pixel pipe and game flow
    int          m_h;
    int          m_v;
    logic        m_vs;
    logic        m_vs_d;
    logic        vs_rise;
    int          s1_h;
    int          s1_v;
    logic        s1_hs;
    logic        s1_vs;
    logic [11:0] s1_rgb;
    logic        exp_hsync;
    logic        exp_vsync;
    logic [11:0] exp_rgb;
    game_state_e exp_state;
    logic        exp_start;
    logic        exp_back;
    int          cooldown;
    int          frames;
    logic        click_in;
    int          menu_btn_px;
    int          over_btn_px;
    int          ignored_clicks;

    game_top #(
        .CLICK_COOLDOWN (CLICK_COOLDOWN),
        .ROUND_FRAMES   (ROUND_FRAMES)
    ) dut_i (
        .clk           (clk),
        .rst           (rst),
        .mouse_x       (mouse_x),
        .mouse_y       (mouse_y),
        .mouse_clicked (mouse_clicked),
        .hsync         (hsync),
        .vsync         (vsync),
        .rgb           (rgb),
        .state         (state)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        // taps 32, 22, 2, 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic in_button(input int x, input int y);
        return (x >= BTN_X) && (x < BTN_X + BTN_W) && (y >= BTN_Y) && (y < BTN_Y + BTN_H);
    endfunction

    function automatic logic [11:0] bg_color(input game_state_e st, input int h, input int v);
        if (h >= HOR_PIXELS || v >= VER_PIXELS)
            return 12'h000;
        case (st)
            STATE_MENU: return COLOR_MENU;
            STATE_PLAY: return COLOR_PLAY;
            default:    return COLOR_OVER;
        endcase
    endfunction

    function automatic logic [11:0] overlay(input game_state_e st, input int h, input int v,
                                            input logic [11:0] base);
        int          idx;
        logic [11:0] px;
        if (st == STATE_PLAY || !in_button(h, v))
            return base;
        idx = ((v - BTN_Y) / 16) * SPRITE_W + (h - BTN_X) / 16;
        px  = (st == STATE_OVER) ? again_px[idx] : start_px[idx];
        return (px == TRANSPARENT) ? base : px;
    endfunction

    assign click_in = in_button(int'(mouse_x), int'(mouse_y));
    assign m_vs     = (m_v >= VER_SYNC_START) && (m_v < VER_SYNC_END);
    assign vs_rise  = m_vs && !m_vs_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m_h <= 0;
            m_v <= 0;
            m_vs_d <= 1'b0;
            s1_h <= 0;
            s1_v <= 0;
            s1_hs <= 1'b0;
            s1_vs <= 1'b0;
            s1_rgb <= '0;
            exp_hsync <= 1'b0;
            exp_vsync <= 1'b0;
            exp_rgb <= '0;
            exp_state <= STATE_MENU;
            exp_start <= 1'b0;
            exp_back <= 1'b0;
            cooldown <= 0;
            frames <= 0;
            menu_btn_px <= 0;
            over_btn_px <= 0;
            ignored_clicks <= 0;
        end else begin
            if (m_h == HOR_TOTAL - 1) begin
                m_h <= 0;
                m_v <= (m_v == VER_TOTAL - 1) ? 0 : m_v + 1;
            end else begin
                m_h <= m_h + 1;
            end
            m_vs_d <= m_vs;

            s1_h <= m_h;   // background stage
            s1_v <= m_v;
            s1_hs <= (m_h >= HOR_SYNC_START) && (m_h < HOR_SYNC_END);
            s1_vs <= m_vs;
            s1_rgb <= bg_color(exp_state, m_h, m_v);
            exp_hsync <= s1_hs;   // overlay stage
            exp_vsync <= s1_vs;
            exp_rgb <= overlay(exp_state, s1_h, s1_v, s1_rgb);
            if (in_button(s1_h, s1_v) && exp_state == STATE_MENU)
                menu_btn_px <= menu_btn_px + 1;
            if (in_button(s1_h, s1_v) && exp_state == STATE_OVER)
                over_btn_px <= over_btn_px + 1;

            // one cooldown shared by both buttons
            exp_start <= 1'b0;
            exp_back <= 1'b0;
            if (cooldown > 0)
                cooldown <= cooldown - 1;
            if (mouse_clicked && click_in && cooldown == 0) begin
                if (exp_state == STATE_MENU) begin
                    exp_start <= 1'b1;
                    cooldown <= CLICK_COOLDOWN;
                end else if (exp_state == STATE_OVER) begin
                    exp_back <= 1'b1;
                    cooldown <= CLICK_COOLDOWN;
                end
            end
            if (mouse_clicked && click_in && cooldown != 0 && exp_state == STATE_MENU)
                ignored_clicks <= ignored_clicks + 1;

            case (exp_state)
                STATE_MENU: begin
                    if (exp_start) begin
                        exp_state <= STATE_PLAY;
                        frames <= 0;
                    end
                end
                STATE_PLAY: begin
                    if (vs_rise) begin
                        if (frames == ROUND_FRAMES - 1)
                            exp_state <= STATE_OVER;
                        else
                            frames <= frames + 1;
                    end
                end
                default: begin
                    if (exp_back)
                        exp_state <= STATE_MENU;
                end
            endcase
        end
    end

    task automatic abort_run(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    a_hsync: assert property (@(posedge clk) disable iff (rst) hsync == exp_hsync)
        else abort_run($sformatf("hsync %0b, expected %0b", hsync, exp_hsync));
    a_vsync: assert property (@(posedge clk) disable iff (rst) vsync == exp_vsync)
        else abort_run($sformatf("vsync %0b, expected %0b", vsync, exp_vsync));
    a_rgb: assert property (@(posedge clk) disable iff (rst) rgb == exp_rgb)
        else abort_run($sformatf("rgb %h, expected %h", rgb, exp_rgb));
    a_state: assert property (@(posedge clk) disable iff (rst) state == exp_state)
        else abort_run($sformatf("state %0d, expected %0d", state, exp_state));

    a_start_click: assert property (@(posedge clk) disable iff (rst)
        (mouse_clicked && click_in && exp_state == STATE_MENU && cooldown == 0)
        |-> ##2 (state == STATE_PLAY))
        else abort_run("start click did not enter play");
    a_outside_click: assert property (@(posedge clk) disable iff (rst)
        (mouse_clicked && !click_in && exp_state == STATE_MENU && !exp_start)
        |-> ##2 (state == STATE_MENU))
        else abort_run("click outside the button left the menu");
    a_round_end: assert property (@(posedge clk) disable iff (rst)
        (exp_state == STATE_PLAY && vs_rise && frames == ROUND_FRAMES - 1)
        |=> (state == STATE_OVER))
        else abort_run("round did not end after the set frames");
    a_back_click: assert property (@(posedge clk) disable iff (rst)
        (mouse_clicked && click_in && exp_state == STATE_OVER && cooldown == 0)
        |-> ##2 (state == STATE_MENU))
        else abort_run("again click did not return to menu");
    a_cooldown: assert property (@(posedge clk) disable iff (rst)
        (mouse_clicked && click_in && exp_state == STATE_MENU && cooldown != 0 && !exp_start)
        |-> ##2 (state == STATE_MENU))
        else abort_run("click during cooldown was accepted");

    task automatic lfsr_bits(input int n, output logic [11:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            val  = {val[10:0], lfsr[0]};
        end
    endtask

    task automatic press(input logic [11:0] x, input logic [11:0] y);
        @(posedge clk);
        mouse_x       <= x;
        mouse_y       <= y;
        mouse_clicked <= 1'b1;
        @(posedge clk);
        mouse_clicked <= 1'b0;
    endtask

    task automatic press_inside();
        logic [11:0] dx;
        logic [11:0] dy;
        lfsr_bits(7, dx);
        lfsr_bits(6, dy);
        press(12'(BTN_X) + dx, 12'(BTN_Y) + dy);
    endtask

    task automatic press_outside();
        logic [11:0] x;
        logic [11:0] y;
        lfsr_bits(12, x);
        lfsr_bits(12, y);
        if (in_button(int'(x), int'(y)))
            y = 12'(BTN_Y + BTN_H);   // just below the button
        press(x, y);
    endtask

    task automatic wait_state(input game_state_e s);
        do @(posedge clk); while (state != s);
    endtask

    task automatic wait_row(input int row);
        do @(posedge clk); while (m_v != row);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the test sequence did not finish in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        lfsr          = 32'h2fa3;
        rst           = 1'b1;
        mouse_x       = '0;
        mouse_y       = '0;
        mouse_clicked = 1'b0;
        $readmemh("source/start_button.mem", start_px);
        $readmemh("source/again_button.mem", again_px);
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        wait_row(300);   // menu button has been drawn once
        repeat (4) begin
            press_outside();
            repeat (17) @(posedge clk);
        end
        press_inside();
        wait_state(STATE_PLAY);

        repeat (3) begin   // no effect while playing
            press_inside();
            repeat (50) @(posedge clk);
            press_outside();
            repeat (50) @(posedge clk);
        end
        wait_state(STATE_OVER);

        wait_row(300);   // again button drawn in the next frame
        press_inside();
        wait_state(STATE_MENU);
        repeat (4) @(posedge clk);
        press_inside();   // inside cooldown
        repeat (25) @(posedge clk);
        press_inside();
        wait_state(STATE_PLAY);
        repeat (10) @(posedge clk);

        if (menu_btn_px == 0 || over_btn_px == 0 || ignored_clicks == 0) begin
            $display("not every case was reached: menu button, again button or cooldown");
            $display("Simulation failed");
            $fatal(1, "incomplete run");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire
